// ==== logic/sysctl_csr_pkg.sv ====
// System controller CSR definitions
package sysctl_csr_pkg;

	// Bus word types.
	typedef logic [13:0] csr_addr_t;	// Full CSR address.
	typedef logic [31:0] csr_data_t;	// One CSR data word.
	typedef logic [3:0]  reg_idx_t;		// Address bits 3..0.
	typedef logic [3:0]  win_id_t;		// Address bits 13..10.

	// GPIO block registers.
	localparam reg_idx_t reg_gpio_in      = 4'd0;	// Read-only, synchronized inputs.
	localparam reg_idx_t reg_gpio_out     = 4'd1;
	localparam reg_idx_t reg_gpio_irqen   = 4'd2;

	// Timer 0 registers.
	localparam reg_idx_t reg_t0_ctrl      = 4'd4;	// Bit 0 enable, bit 1 auto-reload.
	localparam reg_idx_t reg_t0_compare   = 4'd5;
	localparam reg_idx_t reg_t0_counter   = 4'd6;

	// Timer 1 registers, same layout as timer 0 at a 4-word offset.
	localparam reg_idx_t reg_t1_ctrl      = 4'd8;
	localparam reg_idx_t reg_t1_compare   = 4'd9;
	localparam reg_idx_t reg_t1_counter   = 4'd10;

	// Decoder-owned words.
	localparam reg_idx_t reg_icap         = 4'd13;	// No config port here, reads zero.
	localparam reg_idx_t reg_capabilities = 4'd14;	// Read-only.
	localparam reg_idx_t reg_system_id    = 4'd15;	// Write requests the hard reset.

	// Indices 3, 7, 11 and 12 are unused and read as zero.

endpackage

// ==== logic/sysctl_hw_pkg.sv ====
// System controller block definitions
package sysctl_hw_pkg;

	// Counter and compare registers.
	typedef logic [31:0] timer_count_t;

	// Timer control word.
	// Bit 0 is enable, bit 1 is auto-reload.
	typedef logic [1:0] timer_ctrl_t;

	// Compare value after reset, never reached from a zero counter
	// unless the timer is enabled for the full range.
	localparam timer_count_t compare_reset_value = 32'hffff_ffff;

	// Counter value loaded on an auto-reload match.
	// One, since the match cycle itself counts as a tick.
	localparam timer_count_t reload_value = 32'd1;

endpackage

// ==== logic/sysctl_reg_if.sv ====
// Decoder to block register access
interface sysctl_reg_if;

	logic                        we;	// Write strobe, gated by window select.
	sysctl_csr_pkg::reg_idx_t    idx;	// Register index inside the window.
	sysctl_csr_pkg::csr_data_t   wdata;	// Write data.
	sysctl_csr_pkg::csr_data_t   rdata;	// Combinational read data, zero if not ours.

	// Address decoder side.
	modport decoder (
		output we,
		output idx,
		output wdata,
		input  rdata
	);

	// Function block side.
	modport block (
		input  we,
		input  idx,
		input  wdata,
		output rdata
	);

endinterface

// ==== logic/sysctl_gpio.sv ====
// GPIO block
module sysctl_gpio #(
	parameter int ninputs  = 16,	// At most 32.
	parameter int noutputs = 16	// At most 32.
) (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  logic [ninputs-1:0]  gpio_inputs,
	output logic [noutputs-1:0] gpio_outputs,
	output logic                irq,
	sysctl_reg_if.block         bus
);

	logic [ninputs-1:0] gpio_in0;	// First synchronizer stage.
	logic [ninputs-1:0] gpio_in;	// Second stage, safe to use.
	logic [ninputs-1:0] gpio_prev;	// Last cycle's synchronized value.
	logic [ninputs-1:0] gpio_irqen;	// Per-input interrupt enable.
	logic [ninputs-1:0] gpio_diff;

	// Two-stage synchronizer plus history.
	always_ff @(posedge sys_clk) begin
		gpio_in0  <= gpio_inputs;
		gpio_in   <= gpio_in0;
		gpio_prev <= gpio_in;
	end

	// Any level change, either direction.
	assign gpio_diff = gpio_in ^ gpio_prev;

	// Interrupt pulse and CSR writes.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq          <= 1'b0;
			gpio_outputs <= '0;
			gpio_irqen   <= '0;
		end else begin
			irq <= |(gpio_diff & gpio_irqen);	// One cycle per change.
			if (bus.we) begin
				case (bus.idx)
					sysctl_csr_pkg::reg_gpio_out:   gpio_outputs <= bus.wdata[noutputs-1:0];
					sysctl_csr_pkg::reg_gpio_irqen: gpio_irqen   <= bus.wdata[ninputs-1:0];
					default: ;	// Inputs are read-only.
				endcase
			end
		end
	end

	// Read data, zero-extended to the bus word.
	always_comb begin
		case (bus.idx)
			sysctl_csr_pkg::reg_gpio_in:    bus.rdata = sysctl_csr_pkg::csr_data_t'(gpio_in);
			sysctl_csr_pkg::reg_gpio_out:   bus.rdata = sysctl_csr_pkg::csr_data_t'(gpio_outputs);
			sysctl_csr_pkg::reg_gpio_irqen: bus.rdata = sysctl_csr_pkg::csr_data_t'(gpio_irqen);
			default:                        bus.rdata = '0;
		endcase
	end

endmodule

// ==== logic/sysctl_timer.sv ====
// Dual compare timer
module sysctl_timer (
	input  logic        sys_clk,
	input  logic        sys_rst,
	output logic        irq0,
	output logic        irq1,
	sysctl_reg_if.block bus
);

	localparam int nchan = 2;

	// Register indices per channel.
	localparam sysctl_csr_pkg::reg_idx_t ctrl_idx [nchan] = '{
		sysctl_csr_pkg::reg_t0_ctrl, sysctl_csr_pkg::reg_t1_ctrl
	};
	localparam sysctl_csr_pkg::reg_idx_t compare_idx [nchan] = '{
		sysctl_csr_pkg::reg_t0_compare, sysctl_csr_pkg::reg_t1_compare
	};
	localparam sysctl_csr_pkg::reg_idx_t counter_idx [nchan] = '{
		sysctl_csr_pkg::reg_t0_counter, sysctl_csr_pkg::reg_t1_counter
	};

	sysctl_hw_pkg::timer_ctrl_t  ctrl    [nchan];	// {auto-reload, enable}.
	sysctl_hw_pkg::timer_count_t compare [nchan];
	sysctl_hw_pkg::timer_count_t counter [nchan];
	logic [nchan-1:0]            match;
	logic [nchan-1:0]            irq_q;		// Match pulses.

	always_comb begin
		for (int c = 0; c < nchan; c++) begin
			match[c] = counter[c] == compare[c];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq_q <= '0;
			for (int c = 0; c < nchan; c++) begin
				ctrl[c]    <= '0;		// Disabled, no reload.
				counter[c] <= '0;
				compare[c] <= sysctl_hw_pkg::compare_reset_value;
			end
		end else begin
			for (int c = 0; c < nchan; c++) begin
				irq_q[c] <= 1'b0;
				// Count, match and reload rules.
				if (ctrl[c][0]) begin
					if (!match[c]) begin
						counter[c] <= counter[c] + 32'd1;
					end else begin
						irq_q[c] <= 1'b1;
						if (ctrl[c][1])
							counter[c] <= sysctl_hw_pkg::reload_value;	// Runs on.
						else
							ctrl[c][0] <= 1'b0;	// One-shot, stop and hold.
					end
				end
				// CSR writes come last and win.
				if (bus.we) begin
					if (bus.idx == ctrl_idx[c])
						ctrl[c] <= bus.wdata[1:0];
					if (bus.idx == compare_idx[c])
						compare[c] <= bus.wdata;
					if (bus.idx == counter_idx[c])
						counter[c] <= bus.wdata;
				end
			end
		end
	end

	assign irq0 = irq_q[0];
	assign irq1 = irq_q[1];

	// Read data for the six timer registers.
	always_comb begin
		bus.rdata = '0;
		for (int c = 0; c < nchan; c++) begin
			if (bus.idx == ctrl_idx[c])
				bus.rdata = sysctl_csr_pkg::csr_data_t'(ctrl[c]);
			if (bus.idx == compare_idx[c])
				bus.rdata = compare[c];
			if (bus.idx == counter_idx[c])
				bus.rdata = counter[c];
		end
	end

endmodule

// ==== logic/sysctl_regs.sv ====
// CSR window decoder
module sysctl_regs #(
	parameter sysctl_csr_pkg::win_id_t   csr_addr  = 4'h0,
	parameter sysctl_csr_pkg::csr_data_t system_id = 32'habadface
) (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  sysctl_csr_pkg::csr_addr_t csr_a,
	input  logic                      csr_we,
	input  sysctl_csr_pkg::csr_data_t csr_di,
	output sysctl_csr_pkg::csr_data_t csr_do,
	input  sysctl_csr_pkg::csr_data_t capabilities,
	output logic                      hard_reset,
	sysctl_reg_if.decoder             gpio_bus,
	sysctl_reg_if.decoder             timer_bus
);

	sysctl_csr_pkg::win_id_t   win;		// Window number of this access.
	sysctl_csr_pkg::reg_idx_t  idx;		// Register inside the window.
	logic                      selected;
	logic                      wr;		// Write to our window.
	sysctl_csr_pkg::csr_data_t own_rdata;	// Decoder-owned words.
	sysctl_csr_pkg::csr_data_t rdata;	// Combined read data.

	assign win      = csr_a[13:10];
	assign idx      = csr_a[3:0];
	assign selected = win == csr_addr;
	assign wr       = selected & csr_we;

	// Same access to both blocks, each decodes its own indices.
	assign gpio_bus.we     = wr;
	assign gpio_bus.idx    = idx;
	assign gpio_bus.wdata  = csr_di;
	assign timer_bus.we    = wr;
	assign timer_bus.idx   = idx;
	assign timer_bus.wdata = csr_di;

	// Capabilities and identity.
	always_comb begin
		case (idx)
			sysctl_csr_pkg::reg_icap:         own_rdata = '0;	// No config port.
			sysctl_csr_pkg::reg_capabilities: own_rdata = capabilities;
			sysctl_csr_pkg::reg_system_id:    own_rdata = system_id;
			default:                          own_rdata = '0;
		endcase
	end

	// Blocks return zero outside their indices, so an OR merges them.
	assign rdata = gpio_bus.rdata | timer_bus.rdata | own_rdata;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do     <= '0;
			hard_reset <= 1'b0;
		end else begin
			csr_do <= selected ? rdata : '0;	// Zero outside the window.
			// Sticky until the next sys_rst.
			if (wr && idx == sysctl_csr_pkg::reg_system_id)
				hard_reset <= 1'b1;
		end
	end

endmodule

// ==== logic/sysctl.sv ====
// System controller top level
module sysctl #(
	parameter sysctl_csr_pkg::win_id_t   csr_addr  = 4'h0,
	parameter int                        ninputs   = 16,	// At most 32.
	parameter int                        noutputs  = 16,	// At most 32.
	parameter sysctl_csr_pkg::csr_data_t system_id = 32'habadface
) (
	input  logic                      sys_clk,
	input  logic                      sys_rst,

	// CSR bus.
	input  sysctl_csr_pkg::csr_addr_t csr_a,
	input  logic                      csr_we,
	input  sysctl_csr_pkg::csr_data_t csr_di,
	output sysctl_csr_pkg::csr_data_t csr_do,

	// GPIO pins.
	input  logic [ninputs-1:0]        gpio_inputs,
	output logic [noutputs-1:0]       gpio_outputs,

	input  sysctl_csr_pkg::csr_data_t capabilities,	// Static feature word.

	// Interrupt pulses and reset request.
	output logic                      gpio_irq,
	output logic                      timer0_irq,
	output logic                      timer1_irq,
	output logic                      hard_reset
);

	sysctl_reg_if gpio_bus ();
	sysctl_reg_if timer_bus ();

	sysctl_regs #(
		.csr_addr  (csr_addr),
		.system_id (system_id)
	) regs_i (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr_a        (csr_a),
		.csr_we       (csr_we),
		.csr_di       (csr_di),
		.csr_do       (csr_do),
		.capabilities (capabilities),
		.hard_reset   (hard_reset),
		.gpio_bus     (gpio_bus),
		.timer_bus    (timer_bus)
	);

	sysctl_gpio #(
		.ninputs  (ninputs),
		.noutputs (noutputs)
	) gpio_i (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.gpio_inputs  (gpio_inputs),
		.gpio_outputs (gpio_outputs),
		.irq          (gpio_irq),
		.bus          (gpio_bus)
	);

	sysctl_timer timer_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.irq0    (timer0_irq),
		.irq1    (timer1_irq),
		.bus     (timer_bus)
	);

endmodule

// ==== verif/sysctl_clkgen.sv ====
// Clock and reset generator
module sysctl_clkgen #(
	parameter int period       = 40,	// In ns.
	parameter int reset_cycles = 3
) (
	output logic sys_clk,
	output logic sys_rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		sys_clk = 1'b0;
		forever #(period / 2) sys_clk = ~sys_clk;
	end

	// Release on a falling edge, away from the sampling edge.
	initial begin
		sys_rst = 1'b1;
		repeat (reset_cycles) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
	end

endmodule

// ==== verif/sysctl_chk.sv ====
// Interrupt and reset assertions
module sysctl_chk #(
	parameter int nirq = 1
) (
	input logic                      sys_clk,
	input logic                      sys_rst,
	input logic [nirq-1:0]           irq,
	input logic [nirq-1:0]           en,	// Enable behind each irq.
	input sysctl_csr_pkg::csr_data_t outs	// Registers that are zero after reset.
);
	timeunit 1ns;
	timeprecision 100ps;

	// Pulses only.
	irq_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(irq & $past(irq)) == '0) else $error("irq high in two consecutive cycles");

	// Quiet right after reset.
	irq_reset: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$past(sys_rst) |-> irq == '0) else $error("irq high in the cycle after reset");

	// No pulse without an enable in the cycle before.
	irq_enabled: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(irq & ~$past(en)) == '0) else $error("irq raised while not enabled");

	outs_reset: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$past(sys_rst) |-> outs == '0) else $error("outputs not zero after reset");

endmodule

bind sysctl_timer sysctl_chk #(.nirq(2)) timer_chk_i (
	.sys_clk (sys_clk),
	.sys_rst (sys_rst),
	.irq     ({irq1, irq0}),
	.en      ({ctrl[1][0], ctrl[0][0]}),
	.outs    (counter[0] | counter[1])
);

bind sysctl_gpio sysctl_chk #(.nirq(1)) gpio_chk_i (
	.sys_clk (sys_clk),
	.sys_rst (sys_rst),
	.irq     (irq),
	.en      (|gpio_irqen),
	.outs    (sysctl_csr_pkg::csr_data_t'(gpio_outputs))
);

// ==== verif/sysctl_tb.sv ====
// System controller testbench
module sysctl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum {op_write, op_read, op_inputs, op_wait_irq, op_flag, op_pins} op_t;

	typedef struct {
		string                     name;
		op_t                       op;
		sysctl_csr_pkg::csr_addr_t addr;	// Irq select 0..2 for op_wait_irq.
		sysctl_csr_pkg::csr_data_t data;	// Write data, pattern or cycle count.
		sysctl_csr_pkg::csr_data_t exp;		// Used as a mask when rnd is set.
		bit                        rnd;		// Take the LFSR word.
	} row_t;

	localparam sysctl_csr_pkg::win_id_t      win       = 4'd3;
	localparam sysctl_csr_pkg::win_id_t      other_win = 4'd5;
	localparam sysctl_csr_pkg::csr_data_t    caps_word = 32'h0001_0a5c;
	localparam sysctl_hw_pkg::timer_count_t  n_cmp     = 32'd5;	// Timer compare value.

	logic                      sys_clk;
	logic                      sys_rst;
	sysctl_csr_pkg::csr_addr_t csr_a;
	logic                      csr_we;
	sysctl_csr_pkg::csr_data_t csr_di;
	sysctl_csr_pkg::csr_data_t csr_do;
	logic [15:0]               gpio_inputs;
	logic [15:0]               gpio_outputs;
	sysctl_csr_pkg::csr_data_t capabilities;
	logic                      gpio_irq;
	logic                      timer0_irq;
	logic                      timer1_irq;
	logic                      hard_reset;
	logic [31:0]               lfsr = 32'hb56a;
	sysctl_csr_pkg::csr_data_t last_rnd = '0;	// Last word drawn.
	row_t                      rows [$];
	int                        cycles = 0;
	int                        limit = 0;

	sysctl_clkgen clkgen_i (.sys_clk(sys_clk), .sys_rst(sys_rst));

	sysctl #(
		.csr_addr  (win),
		.ninputs   (16),
		.noutputs  (16),
		.system_id (32'habadface)
	) sysctl_i (.*);

	function automatic sysctl_csr_pkg::csr_addr_t win_addr(sysctl_csr_pkg::win_id_t w,
			sysctl_csr_pkg::reg_idx_t i);
		return {w, 6'd0, i};
	endfunction

	// Taps 32, 22, 2, 1; one step per bit taken.
	function automatic sysctl_csr_pkg::csr_data_t next_word();
		sysctl_csr_pkg::csr_data_t w;
		w = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			w    = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic logic irq_line(int sel);
		case (sel)
			0:       return gpio_irq;
			1:       return timer0_irq;
			default: return timer1_irq;
		endcase
	endfunction

	function automatic int expected_cycles(row_t r);
		return (r.op == op_wait_irq) ? int'(r.data) : 1;
	endfunction

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(string name, sysctl_csr_pkg::csr_data_t exp,
			sysctl_csr_pkg::csr_data_t act);
		if (act !== exp)
			stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp)
			stop_on_error($sformatf("mismatch %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_gpio(string name, logic [15:0] exp, logic [15:0] act);
		if (act !== exp)
			stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic add_row(string name, op_t op, sysctl_csr_pkg::csr_addr_t addr,
			sysctl_csr_pkg::csr_data_t data, sysctl_csr_pkg::csr_data_t exp, bit rnd);
		rows.push_back('{name, op, addr, data, exp, rnd});
	endtask

	task automatic build_table();
		// Reset values and identity.
		add_row("rst gpio_in", op_read, win_addr(win, sysctl_csr_pkg::reg_gpio_in), 0, 0, 0);
		add_row("rst gpio_out", op_read, win_addr(win, sysctl_csr_pkg::reg_gpio_out), 0, 0, 0);
		add_row("rst irqen", op_read, win_addr(win, sysctl_csr_pkg::reg_gpio_irqen), 0, 0, 0);
		add_row("rst t0 cmp", op_read, win_addr(win, sysctl_csr_pkg::reg_t0_compare), 0, '1, 0);
		add_row("rst t1 cmp", op_read, win_addr(win, sysctl_csr_pkg::reg_t1_compare), 0, '1, 0);
		add_row("rst t0 cnt", op_read, win_addr(win, sysctl_csr_pkg::reg_t0_counter), 0, 0, 0);
		add_row("rst t1 cnt", op_read, win_addr(win, sysctl_csr_pkg::reg_t1_counter), 0, 0, 0);
		add_row("icap", op_read, win_addr(win, sysctl_csr_pkg::reg_icap), 0, 0, 0);
		add_row("caps", op_read, win_addr(win, sysctl_csr_pkg::reg_capabilities), 0, caps_word, 0);
		add_row("sysid", op_read, win_addr(win, sysctl_csr_pkg::reg_system_id), 0, 'habadface, 0);
		add_row("outside", op_read, win_addr(other_win, sysctl_csr_pkg::reg_system_id), 0, 0, 0);
		add_row("rst pins", op_pins, 0, 0, 0, 0);
		// GPIO outputs and input readback.
		add_row("wr out", op_write, win_addr(win, sysctl_csr_pkg::reg_gpio_out), 0, 0, 1);
		add_row("out pins", op_pins, 0, 0, 'hffff, 1);
		add_row("rd out", op_read, win_addr(win, sysctl_csr_pkg::reg_gpio_out), 0, 'hffff, 1);
		// GPIO interrupt, only bit 0 enabled.
		add_row("wr irqen", op_write, win_addr(win, sysctl_csr_pkg::reg_gpio_irqen), 1, 0, 0);
		add_row("in bit0", op_inputs, 0, 'h1, 0, 0);
		add_row("irq bit0", op_wait_irq, 0, 6, 1, 0);
		add_row("in bit1", op_inputs, 0, 'h3, 0, 0);
		add_row("no irq bit1", op_wait_irq, 0, 6, 0, 0);
		add_row("rd in", op_read, win_addr(win, sysctl_csr_pkg::reg_gpio_in), 0, 'h3, 0);
		add_row("irqen off", op_write, win_addr(win, sysctl_csr_pkg::reg_gpio_irqen), 0, 0, 0);
		add_row("in rnd", op_inputs, 0, 0, 0, 1);
		add_row("no irq rnd", op_wait_irq, 0, 3, 0, 0);
		add_row("rd in rnd", op_read, win_addr(win, sysctl_csr_pkg::reg_gpio_in), 0, 'hffff, 1);
		// One-shot timer 0.
		add_row("t0 cmp", op_write, win_addr(win, sysctl_csr_pkg::reg_t0_compare), n_cmp, 0, 0);
		add_row("t0 cnt", op_write, win_addr(win, sysctl_csr_pkg::reg_t0_counter), 0, 0, 0);
		add_row("t0 go", op_write, win_addr(win, sysctl_csr_pkg::reg_t0_ctrl), 1, 0, 0);
		add_row("t0 irq", op_wait_irq, 1, n_cmp + 2, 1, 0);
		add_row("t0 stopped", op_read, win_addr(win, sysctl_csr_pkg::reg_t0_ctrl), 0, 0, 0);
		add_row("t0 held", op_read, win_addr(win, sysctl_csr_pkg::reg_t0_counter), 0, n_cmp, 0);
		// Auto-reload timer 1, one pulse per n_cmp cycles.
		add_row("t1 cmp", op_write, win_addr(win, sysctl_csr_pkg::reg_t1_compare), n_cmp, 0, 0);
		add_row("t1 go", op_write, win_addr(win, sysctl_csr_pkg::reg_t1_ctrl), 3, 0, 0);
		add_row("t1 irqs", op_wait_irq, 2, 3 * (n_cmp - 1) + n_cmp, 3, 0);
		add_row("t1 running", op_read, win_addr(win, sysctl_csr_pkg::reg_t1_ctrl), 0, 3, 0);
		// Hard reset request.
		add_row("hr idle", op_flag, 0, 0, 0, 0);
		add_row("hr other", op_write, win_addr(other_win, sysctl_csr_pkg::reg_system_id), 1, 0, 0);
		add_row("hr not set", op_flag, 0, 0, 0, 0);
		add_row("hr write", op_write, win_addr(win, sysctl_csr_pkg::reg_system_id), 1, 0, 0);
		add_row("hr set", op_flag, 0, 0, 1, 0);
		add_row("t0 quiet", op_wait_irq, 1, 4, 0, 0);
		add_row("hr sticky", op_flag, 0, 0, 1, 0);
	endtask

	// Each row starts and ends on a falling edge.
	task automatic apply_row(row_t r);
		sysctl_csr_pkg::csr_data_t d;
		sysctl_csr_pkg::csr_data_t e;
		int                        count;
		d = r.data;
		e = r.exp;
		count = 0;
		if (r.rnd && (r.op == op_write || r.op == op_inputs)) begin
			last_rnd = next_word();
			d = last_rnd;
		end else if (r.rnd) begin
			e = last_rnd & r.exp;
		end
		case (r.op)
			op_write: begin
				csr_a  = r.addr;
				csr_di = d;
				csr_we = 1'b1;
				@(negedge sys_clk);
				csr_we = 1'b0;
			end
			op_read: begin
				csr_a = r.addr;
				@(negedge sys_clk);	// csr_do is registered.
				check_data(r.name, e, csr_do);
			end
			op_inputs: begin
				gpio_inputs = d[15:0];
				@(negedge sys_clk);
			end
			op_wait_irq: begin
				repeat (d) begin
					@(negedge sys_clk);
					if (irq_line(int'(r.addr)))
						count++;
				end
				check_data(r.name, e, count);	// Pulse count.
			end
			op_flag: check_flag(r.name, e[0], hard_reset);
			default: check_gpio(r.name, e[15:0], gpio_outputs);
		endcase
	endtask

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
			stop_on_error($sformatf("timeout: table not done after %0d cycles", cycles));
	end

	initial begin
		int total;
		csr_a        = '0;
		csr_we       = 1'b0;
		csr_di       = '0;
		gpio_inputs  = '0;
		capabilities = caps_word;
		total        = 0;
		build_table();
		foreach (rows[i])
			total += expected_cycles(rows[i]);
		limit = 8 * total;
		wait (sys_rst === 1'b0);
		@(negedge sys_clk);
		foreach (rows[i])
			apply_row(rows[i]);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== sysctl.f ====
logic/sysctl_csr_pkg.sv
logic/sysctl_hw_pkg.sv
logic/sysctl_reg_if.sv
logic/sysctl_gpio.sv
logic/sysctl_timer.sv
logic/sysctl_regs.sv
logic/sysctl.sv
verif/sysctl_clkgen.sv
verif/sysctl_chk.sv
verif/sysctl_tb.sv
